/* Makefile */
# Verilator simulation of the RV32I pipeline core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module tb_core -Mdir obj_dir -f verilog.f
	@out="$$(./obj_dir/Vtb_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* logic/alu.sv */
`include "core_config.svh"

// Execute stage, all integer ops plus pass-through of memory control
module alu (
    input  core_pkg::ex_ctrl_t  ex,
    output core_pkg::mem_ctrl_t mem
);
    import core_pkg::*;

    logic [$clog2(`CORE_XLEN)-1:0] shamt;  // Low five bits of operand B
    logic                          lt_s;
    logic                          lt_u;

    assign shamt = ex.operand_b[$clog2(`CORE_XLEN)-1:0];
    assign lt_s  = $signed(ex.operand_a) < $signed(ex.operand_b);
    assign lt_u  = ex.operand_a < ex.operand_b;

    always_comb begin
        // Memory control rides along unchanged
        mem.store_data = ex.store_data;
        mem.mem_op     = ex.mem_op;
        mem.width      = ex.width;
        mem.rd         = ex.rd;
        mem.wb_en      = ex.wb_en;

        case (ex.alu_op)
            ADD:     mem.result = ex.operand_a + ex.operand_b;  // Also load/store address
            SUB:     mem.result = ex.operand_a - ex.operand_b;
            SLL:     mem.result = ex.operand_a << shamt;
            SLT:     mem.result = {{(`CORE_XLEN-1){1'b0}}, lt_s};
            SLTU:    mem.result = {{(`CORE_XLEN-1){1'b0}}, lt_u};
            XOR:     mem.result = ex.operand_a ^ ex.operand_b;
            SRL:     mem.result = ex.operand_a >> shamt;
            SRA:     mem.result = $signed(ex.operand_a) >>> shamt;  // Sign fill
            OR:      mem.result = ex.operand_a | ex.operand_b;
            AND:     mem.result = ex.operand_a & ex.operand_b;
            default: mem.result = '0;
        endcase
    end

endmodule

/* logic/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ******************************
// Core widths
// ******************************

`define CORE_XLEN        32     // Data and instruction width
`define CORE_REG_ADDR_W  5      // Register index width
`define CORE_DATA_ADDR_W 16     // Data-memory address bus width

// ******************************
// Program counter
// ******************************

`define CORE_PC_STEP     4      // Byte step between sequential instructions
`define CORE_RESET_PC    0      // First fetch address after reset

`endif

/* logic/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

    // Major opcodes kept by the core, anything else decodes to a bubble
    typedef enum logic [6:0] {
        BUBBLE = 7'b000_0000,       // All-zero word
        LOAD   = 7'b000_0011,
        OP_IMM = 7'b001_0011,
        STORE  = 7'b010_0011,
        OP     = 7'b011_0011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } mem_op_e;

    // Access size and extension for loads and stores
    typedef enum logic [2:0] {
        WORD, HALF_S, HALF_U, BYTE_S, BYTE_U
    } width_e;

    // ******************************
    // Stage structs
    // ******************************

    typedef struct packed {
        alu_op_e                     alu_op;
        logic [`CORE_XLEN-1:0]       operand_a;
        logic [`CORE_XLEN-1:0]       operand_b;
        logic [`CORE_XLEN-1:0]       store_data;  // rs2 value for stores
        mem_op_e                     mem_op;
        width_e                      width;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic                        wb_en;
    } ex_ctrl_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]       result;      // ALU output or memory address
        logic [`CORE_XLEN-1:0]       store_data;
        mem_op_e                     mem_op;
        width_e                      width;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic                        wb_en;
    } mem_ctrl_t;

    typedef struct packed {
        logic                        wb_en;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       data;
    } wb_t;

    // Bubble contents, no memory access and no register write
    localparam ex_ctrl_t EX_BUBBLE = '{alu_op: ADD, operand_a: '0, operand_b: '0,
                                       store_data: '0, mem_op: MEM_NONE, width: WORD,
                                       rd: '0, wb_en: 1'b0};
    localparam mem_ctrl_t MEM_BUBBLE = '{result: '0, store_data: '0, mem_op: MEM_NONE,
                                         width: WORD, rd: '0, wb_en: 1'b0};
    localparam wb_t WB_IDLE = '{wb_en: 1'b0, rd: '0, data: '0};

endpackage

/* logic/data_access_stage.sv */
`include "core_config.svh"

// Memory stage, drives the data port and registers the write-back value
module data_access_stage (
    input  logic                         CK_REF,
    input  logic                         RST_N,
    input  core_pkg::mem_ctrl_t          mem,
    input  logic [`CORE_XLEN-1:0]        data_rdata,
    output logic                         data_rd_wrn,
    output logic [`CORE_DATA_ADDR_W-1:0] data_addr,
    output logic [`CORE_XLEN-1:0]        data_wdata,
    output core_pkg::wb_t                wb
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0] load_data;

    // Byte and half extension, shared by store data and load data
    function automatic logic [`CORE_XLEN-1:0] extend(
        input logic [`CORE_XLEN-1:0] value,
        input width_e                size
    );
        logic [`CORE_XLEN-1:0] ext;
        case (size)
            BYTE_S:  ext = {{(`CORE_XLEN-8){value[7]}}, value[7:0]};
            BYTE_U:  ext = {{(`CORE_XLEN-8){1'b0}}, value[7:0]};
            HALF_S:  ext = {{(`CORE_XLEN-16){value[15]}}, value[15:0]};
            HALF_U:  ext = {{(`CORE_XLEN-16){1'b0}}, value[15:0]};
            default: ext = value;  // WORD
        endcase
        return ext;
    endfunction

    // ******************************
    // Data-memory port
    // ******************************
    always_comb begin
        data_rd_wrn = 1'b1;   // Idle reads as high
        data_addr   = '0;
        data_wdata  = '0;
        case (mem.mem_op)
            MEM_LOAD: begin
                data_addr = mem.result[`CORE_DATA_ADDR_W-1:0];
            end
            MEM_STORE: begin
                data_rd_wrn = 1'b0;
                data_addr   = mem.result[`CORE_DATA_ADDR_W-1:0];
                data_wdata  = extend(mem.store_data, mem.width);  // SB/SH sign-extended
            end
            default: ;
        endcase
    end

    assign load_data = extend(data_rdata, mem.width);

    // Write-back register
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            wb <= WB_IDLE;
        end else begin
            wb.wb_en <= mem.wb_en;
            wb.rd    <= mem.rd;
            wb.data  <= (mem.mem_op == MEM_LOAD) ? load_data : mem.result;
        end
    end

endmodule

/* logic/instr_decoder.sv */
`include "core_config.svh"

// Decode stage, fetch word plus register values into execute control
module instr_decoder (
    input  logic [`CORE_XLEN-1:0]       instr,
    input  logic [`CORE_XLEN-1:0]       rs1_data,
    input  logic [`CORE_XLEN-1:0]       rs2_data,
    output logic [`CORE_REG_ADDR_W-1:0] rs1_addr,
    output logic [`CORE_REG_ADDR_W-1:0] rs2_addr,
    output core_pkg::ex_ctrl_t          ctrl
);
    import core_pkg::*;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic                  alt;           // Bit 30, SUB and SRA select
    logic                  f7_rest_zero;  // Remaining funct7 bits clear
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    alu_op_e               alu_sel;
    logic                  legal;

    assign opcode       = opcode_e'(instr[6:0]);
    assign funct3       = instr[14:12];
    assign alt          = instr[30];
    assign f7_rest_zero = (instr[31] == 1'b0) && (instr[29:25] == 5'b0_0000);

    // Register read addresses straight from the word
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Sign-extended immediates
    assign imm_i = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`CORE_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    // ******************************
    // ALU op from funct3
    // ******************************
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (opcode == OP && alt) ? SUB : ADD;  // ADDI ignores bit 30
            3'b001:  alu_sel = SLL;
            3'b010:  alu_sel = SLT;
            3'b011:  alu_sel = SLTU;
            3'b100:  alu_sel = XOR;
            3'b101:  alu_sel = alt ? SRA : SRL;
            3'b110:  alu_sel = OR;
            default: alu_sel = AND;
        endcase
    end

    // ******************************
    // Control struct
    // ******************************
    always_comb begin
        ctrl  = EX_BUBBLE;
        legal = 1'b0;
        case (opcode)
            OP: begin
                ctrl.alu_op    = alu_sel;
                ctrl.operand_a = rs1_data;
                ctrl.operand_b = rs2_data;
                ctrl.rd        = instr[11:7];
                ctrl.wb_en     = 1'b1;
                // Bit 30 only valid for SUB and SRA
                legal = f7_rest_zero && (!alt || funct3 == 3'b000 || funct3 == 3'b101);
            end
            OP_IMM: begin
                ctrl.alu_op    = alu_sel;
                ctrl.operand_a = rs1_data;
                ctrl.operand_b = imm_i;  // Shifts use the low bits only
                ctrl.rd        = instr[11:7];
                ctrl.wb_en     = 1'b1;
                if (funct3 == 3'b001) begin
                    legal = f7_rest_zero && !alt;  // SLLI
                end else if (funct3 == 3'b101) begin
                    legal = f7_rest_zero;          // SRLI or SRAI
                end else begin
                    legal = 1'b1;
                end
            end
            LOAD: begin
                ctrl.operand_a = rs1_data;
                ctrl.operand_b = imm_i;
                ctrl.mem_op    = MEM_LOAD;
                ctrl.rd        = instr[11:7];
                ctrl.wb_en     = 1'b1;
                legal          = 1'b1;
                case (funct3)
                    3'b000:  ctrl.width = BYTE_S;   // LB
                    3'b001:  ctrl.width = HALF_S;   // LH
                    3'b010:  ctrl.width = WORD;     // LW
                    3'b100:  ctrl.width = BYTE_U;   // LBU
                    3'b101:  ctrl.width = HALF_U;   // LHU
                    default: legal = 1'b0;
                endcase
            end
            STORE: begin
                ctrl.operand_a  = rs1_data;
                ctrl.operand_b  = imm_s;
                ctrl.store_data = rs2_data;
                ctrl.mem_op     = MEM_STORE;
                legal           = 1'b1;
                case (funct3)
                    3'b000:  ctrl.width = BYTE_S;   // SB
                    3'b001:  ctrl.width = HALF_S;   // SH
                    3'b010:  ctrl.width = WORD;     // SW
                    default: legal = 1'b0;
                endcase
            end
            BUBBLE:  legal = 1'b0;
            default: legal = 1'b0;  // Branches, jumps, LUI, AUIPC, system
        endcase

        if (!legal) begin
            ctrl = EX_BUBBLE;
        end
        // x0 is never written
        if (ctrl.rd == '0) begin
            ctrl.wb_en = 1'b0;
        end
    end

endmodule

/* logic/program_counter.sv */
`include "core_config.svh"

// Free-running instruction address counter
module program_counter (
    input  logic                  CK_REF,
    input  logic                  RST_N,
    output logic [`CORE_XLEN-1:0] pc
);

    logic [`CORE_XLEN-1:0] pc_next;

    // Sequential step only, branch target select would go here
    assign pc_next = pc + `CORE_XLEN'(`CORE_PC_STEP);

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            pc <= `CORE_XLEN'(`CORE_RESET_PC);  // Start of program
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* logic/register_file.sv */
`include "core_config.svh"

// Two read ports, one write port, write-through on read
module register_file (
    input  logic                        CK_REF,
    input  logic                        RST_N,
    input  logic [`CORE_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`CORE_REG_ADDR_W-1:0] rs2_addr,
    input  core_pkg::wb_t               wb,
    output logic [`CORE_XLEN-1:0]       rs1_data,
    output logic [`CORE_XLEN-1:0]       rs2_data
);

    localparam int NREGS = 1 << `CORE_REG_ADDR_W;

    logic [`CORE_XLEN-1:0] regs [1:NREGS-1];  // x0 has no storage

    // Read with x0 and same-cycle write bypass
    function automatic logic [`CORE_XLEN-1:0] read_port(
        input logic [`CORE_REG_ADDR_W-1:0] addr
    );
        logic [`CORE_XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wb.wb_en && wb.rd == addr) begin
            value = wb.data;                // Write-through
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wb_en && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

/* logic/riscv_core.sv */
`include "core_config.svh"

// Five-stage RV32I integer pipeline, no forwarding and no stalls
module riscv_core (
    input  logic                         CK_REF,
    input  logic                         RST_N,
    output logic [`CORE_XLEN-1:0]        inst_addr,
    input  logic [`CORE_XLEN-1:0]        inst_data,
    output logic                         data_rd_wrn,
    output logic [`CORE_DATA_ADDR_W-1:0] data_addr,
    output logic [`CORE_XLEN-1:0]        data_wdata,
    input  logic [`CORE_XLEN-1:0]        data_rdata
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0]       fetch_q;   // Fetched instruction word
    logic [`CORE_REG_ADDR_W-1:0] rs1_addr;
    logic [`CORE_REG_ADDR_W-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]       rs1_data;
    logic [`CORE_XLEN-1:0]       rs2_data;
    ex_ctrl_t                    ex_d;
    ex_ctrl_t                    ex_q;      // Decode/execute register
    mem_ctrl_t                   mem_d;
    mem_ctrl_t                   mem_q;     // Execute/memory register
    wb_t                         wb;        // Write-back register, inside memory stage

    // ******************************
    // Fetch
    // ******************************
    program_counter u_pc (
        .CK_REF (CK_REF),
        .RST_N  (RST_N),
        .pc     (inst_addr)
    );

    // ******************************
    // Decode and register read
    // ******************************
    instr_decoder u_dec (
        .instr    (fetch_q),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .ctrl     (ex_d)
    );

    register_file u_rf (
        .CK_REF   (CK_REF),
        .RST_N    (RST_N),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ******************************
    // Execute and memory
    // ******************************
    alu u_alu (
        .ex  (ex_q),
        .mem (mem_d)
    );

    data_access_stage u_mem (
        .CK_REF      (CK_REF),
        .RST_N       (RST_N),
        .mem         (mem_q),
        .data_rdata  (data_rdata),
        .data_rd_wrn (data_rd_wrn),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .wb          (wb)
    );

    // Pipeline registers, reset to bubbles
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            fetch_q <= '0;          // All-zero word is a bubble
            ex_q    <= EX_BUBBLE;
            mem_q   <= MEM_BUBBLE;
        end else begin
            fetch_q <= inst_data;
            ex_q    <= ex_d;
            mem_q   <= mem_d;
        end
    end

endmodule

/* testbench/tb_clock.sv */
// Clock and power-on reset for the core testbench
module tb_clock (
    output logic CK_REF,
    output logic RST_N
);

    localparam int HALF_PERIOD  = 10;  // 20 unit period
    localparam int RESET_CYCLES = 3;

    initial begin
        CK_REF = 1'b0;
        forever #HALF_PERIOD CK_REF = ~CK_REF;
    end

    initial begin
        RST_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge CK_REF);
        RST_N <= 1'b1;                 // Release on a rising edge
    end

endmodule

/* testbench/tb_core.sv */
`include "core_config.svh"

module tb_core;

    localparam int IMEM_WORDS = 1024;
    localparam int DMEM_WORDS = 1 << (`CORE_DATA_ADDR_W - 2);
    localparam int LAT        = 3;        // Fetch edge to store edge
    localparam logic [6:0] OPC_LOAD  = 7'h03;
    localparam logic [6:0] OPC_IMM   = 7'h13;
    localparam logic [6:0] OPC_STORE = 7'h23;
    localparam logic [6:0] OPC_REG   = 7'h33;

    logic                         CK_REF;
    logic                         RST_N;
    logic [`CORE_XLEN-1:0]        inst_addr;
    logic [`CORE_XLEN-1:0]        inst_data;
    logic                         data_rd_wrn;
    logic [`CORE_DATA_ADDR_W-1:0] data_addr;
    logic [`CORE_XLEN-1:0]        data_wdata;
    logic [`CORE_XLEN-1:0]        data_rdata;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] ref_mem [0:DMEM_WORDS-1];   // Reference copy of data memory
    logic [31:0] preset [0:31];              // Operand and load words at 0x000
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_slot [$];               // Edge index of each store
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];
    int          edge_n    = 0;              // Rising edges since reset release
    int          rst_edges = 0;
    int          limit     = 0;
    int          st_off    = -512;           // Next store offset from x30

    tb_clock u_clk (
        .CK_REF (CK_REF),
        .RST_N  (RST_N)
    );

    riscv_core dut0 (
        .CK_REF      (CK_REF),
        .RST_N       (RST_N),
        .inst_addr   (inst_addr),
        .inst_data   (inst_data),
        .data_rd_wrn (data_rd_wrn),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata)
    );

    // Both memories answer in the same cycle
    assign inst_data  = imem[inst_addr[11:2]];
    assign data_rdata = dmem[data_addr[15:2]];

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        logic [13:0] widx;
        logic [31:0] value;
        widx = 14'(idx);
        if (idx < 32) begin
            value = preset[idx];
        end else begin
            value = {16'hDA7A, widx, 2'b00};   // Byte address in the low half
        end
        return value;
    endfunction

    // ******************************
    // Instruction encoders
    // ******************************
    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    // Word plus two bubbles keeps readers three slots behind writers
    task automatic append_spaced(input logic [31:0] word);
        prog.push_back(word);
        prog.push_back(32'h0);
        prog.push_back(32'h0);
    endtask

    task automatic store_reg(input logic [4:0] rs2, input logic [2:0] f3);
        append_spaced(stype_word(12'(st_off), rs2, 5'd30, f3));  // Negative offset from x30
        st_off = st_off + 4;
    endtask

    task automatic build_program();
        logic [11:0] imm;
        append_spaced(itype_word(12'h700, 5'd0, 3'b000, 5'd30, OPC_IMM));  // Store base
        for (int r = 1; r <= 8; r++) begin
            append_spaced(itype_word(12'(4 * (r - 1)), 5'd0, 3'b010, 5'(r), OPC_LOAD));
        end
        // Immediate ops into x10
        for (int f = 0; f < 8; f++) begin
            imm = 12'($urandom);
            if (f == 1 || f == 5) begin
                imm = {7'b0, imm[4:0]};          // SLLI and SRLI shamt only
            end
            append_spaced(itype_word(imm, 5'(1 + f), 3'(f), 5'd10, OPC_IMM));
            store_reg(5'd10, 3'b010);
        end
        append_spaced(itype_word({7'b010_0000, 5'($urandom)}, 5'd4, 3'b101, 5'd10, OPC_IMM));
        store_reg(5'd10, 3'b010);                // SRAI on a negative value
        // Register-register ops into x11
        for (int f = 0; f < 8; f++) begin
            append_spaced(rtype_word(7'h00, 5'(8 - f), 5'(1 + f), 3'(f), 5'd11));
            store_reg(5'd11, 3'b010);
        end
        append_spaced(rtype_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd11));   // SUB
        store_reg(5'd11, 3'b010);
        append_spaced(rtype_word(7'h20, 5'd5, 5'd2, 3'b101, 5'd11));   // SRA of negative x2
        store_reg(5'd11, 3'b010);
        append_spaced(rtype_word(7'h00, 5'd5, 5'd2, 3'b010, 5'd11));   // SLT
        store_reg(5'd11, 3'b010);
        append_spaced(rtype_word(7'h00, 5'd5, 5'd2, 3'b011, 5'd11));   // SLTU
        store_reg(5'd11, 3'b010);
        // ******************************
        // Loads with extension and narrow stores
        // ******************************
        for (int j = 0; j < 5; j++) begin
            append_spaced(itype_word(12'(64 + 4 * j), 5'd0, 3'(j < 3 ? j : j + 1), 5'd12,
                                     OPC_LOAD));  // LB LH LW LBU LHU
            store_reg(5'd12, 3'b010);
        end
        store_reg(5'd2, 3'b000);                 // SB
        store_reg(5'd4, 3'b001);                 // SH
        store_reg(5'd1, 3'b000);
        store_reg(5'd3, 3'b001);
        // Unsupported words must leave x13 alone
        append_spaced(itype_word(12'h123, 5'd0, 3'b000, 5'd13, OPC_IMM));
        append_spaced(32'h0000_0063);            // BEQ x0, x0, 0
        append_spaced(32'h0080_06EF);            // JAL x13, +8
        append_spaced(32'hABCD_E6B7);            // LUI x13, 0xABCDE
        append_spaced(itype_word(12'h055, 5'd1, 3'b000, 5'd0, OPC_IMM));  // ADDI x0
        append_spaced(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));       // ADD x0
        store_reg(5'd13, 3'b010);
        store_reg(5'd0, 3'b010);
    endtask

    // ******************************
    // Reference ISA model
    // ******************************
    function automatic void reference_run();
        logic [31:0] x [0:31];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [2:0]  f3;
        logic        wr;
        for (int i = 0; i < 32; i++) begin
            x[i] = 32'h0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_mem[i] = fill_word(i);
        end
        for (int s = 0; s < prog.size(); s++) begin
            w    = prog[s];
            f3   = w[14:12];
            a    = x[w[19:15]];
            b    = (w[6:0] == OPC_REG) ? x[w[24:20]] : {{20{w[31]}}, w[31:20]};
            addr = a + b;                         // Load address
            wr   = 1'b0;
            res  = 32'h0;
            if (w[6:0] == OPC_REG || w[6:0] == OPC_IMM) begin
                wr = 1'b1;
                case (f3)
                    3'b000:  res = (w[6:0] == OPC_REG && w[30]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  res = {31'b0, a < b};
                    3'b100:  res = a ^ b;
                    3'b101: begin
                        if (w[30]) begin
                            res = $signed(a) >>> b[4:0];
                        end else begin
                            res = a >> b[4:0];
                        end
                    end
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end else if (w[6:0] == OPC_LOAD) begin
                wr  = 1'b1;
                res = ref_mem[addr[15:2]];
                case (f3)
                    3'b000:  res = {{24{res[7]}}, res[7:0]};
                    3'b001:  res = {{16{res[15]}}, res[15:0]};
                    3'b100:  res = {24'h0, res[7:0]};
                    3'b101:  res = {16'h0, res[15:0]};
                    default: ;
                endcase
            end else if (w[6:0] == OPC_STORE) begin
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                res  = x[w[24:20]];
                if (f3 == 3'b000) begin
                    res = {{24{res[7]}}, res[7:0]};      // Sign-extended byte fills the word
                end else if (f3 == 3'b001) begin
                    res = {{16{res[15]}}, res[15:0]};
                end
                ref_mem[addr[15:2]] = res;
                exp_addr.push_back({16'h0, addr[15:0]});
                exp_data.push_back(res);
                exp_slot.push_back(s + LAT);
            end
            if (wr && w[11:7] != 5'd0) begin
                x[w[11:7]] = res;
            end
        end
    endfunction

    // Data memory model and store compare on pre-edge values
    always @(posedge CK_REF) begin
        if (!RST_N) begin
            if (rst_edges == 0) begin
                for (int i = 0; i < DMEM_WORDS; i++) begin
                    dmem[i] = fill_word(i);
                end
            end else begin
                check("inst_addr", inst_addr, 32'h0);
                check("data_rd_wrn", {31'b0, data_rd_wrn}, 32'h1);
            end
            rst_edges <= rst_edges + 1;
        end else begin
            edge_n <= edge_n + 1;
            check("inst_addr", inst_addr, 32'(4 * edge_n));   // PC steps by 4
            if (edge_n < LAT) begin
                check("data_rd_wrn", {31'b0, data_rd_wrn}, 32'h1);  // Pipeline still empty
            end
            if (edge_n > limit) begin
                stop_run("Timeout: the program did not drain within the cycle limit");
            end else if (!data_rd_wrn) begin
                if (log_addr.size() >= exp_addr.size()) begin
                    stop_run("A store appeared on the data bus that the program does not hold");
                end else begin
                    log_addr.push_back({16'h0, data_addr});
                    log_data.push_back(data_wdata);
                    check("data_addr", log_addr[log_addr.size() - 1],
                          exp_addr[log_addr.size() - 1]);
                    check("data_wdata", log_data[log_data.size() - 1],
                          exp_data[log_data.size() - 1]);
                    check("store_edge", 32'(edge_n), 32'(exp_slot[log_addr.size() - 1]));
                    dmem[data_addr[15:2]] = data_wdata;
                end
            end else begin
                check("data_wdata", data_wdata, 32'h0);  // Bus idle outside stores
            end
        end
    end

    initial begin
        void'($urandom(19));
        for (int i = 0; i < 32; i++) begin
            preset[i] = $urandom;
        end
        preset[1] = preset[1] | 32'h8000_8080;   // x2 and x4 negative in every width
        preset[3] = preset[3] | 32'h8000_8080;
        for (int i = 16; i < 21; i++) begin
            preset[i] = preset[i] | 32'h8000_8080;   // Load words with the top bits set
        end
        build_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
        end
        reference_run();
        limit = prog.size() + 20;
        @(posedge RST_N);
        // Last word fetched and drained through write-back
        while (inst_addr < 32'(4 * (prog.size() + 4))) begin
            @(negedge CK_REF);
        end
        if (log_addr.size() != exp_addr.size()) begin
            stop_run("Fewer stores appeared on the data bus than the program holds");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+logic
logic/core_pkg.sv
logic/program_counter.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/data_access_stage.sv
logic/riscv_core.sv
testbench/tb_clock.sv
testbench/tb_core.sv
